//--- src/cpc_pkg.sv
package cpc_pkg;

	// Bus widths
	localparam int MEM_ADDR_W = 23;
	localparam int PAGE_W     = 8;  // Expansion page index
	localparam int PAGE_OFS_W = 14; // 16 KB page offset
	localparam int CPU_ADDR_W = 16;
	localparam int MF2_ADDR_W = 13; // 8 KB Multiface RAM

	// Memory pages, upper 9 address bits
	localparam logic [8:0] MAIN_ROM_PAGE_LO     = 9'h000;
	localparam logic [8:0] MAIN_ROM_PAGE_BASIC  = 9'h100;
	localparam logic [8:0] MAIN_ROM_PAGE_AMSDOS = 9'h107;
	localparam logic [8:0] MF2_ROM_PAGE         = 9'h1FF;

	// Pages 0, 7 and 255 are always fitted
	localparam logic [255:0] DEFAULT_ROM_PAGES = (256'd1 << 255) | (256'd1 << 7) | 256'd1;

	// Multiface CPU and port addresses
	localparam logic [15:0] MF2_NMI_ENTRY = 16'h0066;
	localparam logic [15:0] MF2_HIDE_ADDR = 16'h0065;
	localparam logic [15:0] MF2_PORT_BASE = 16'hFEE8; // Bit 1 low enables

	// I/O port high bytes
	localparam logic [7:0] PORT_GA       = 8'h7F;
	localparam logic [7:0] PORT_CRTC_SEL = 8'hBC;
	localparam logic [7:0] PORT_CRTC_VAL = 8'hBD;
	localparam logic [7:0] PORT_PPI_CTRL = 8'hF7;
	localparam logic [7:0] PORT_ROM_SEL  = 8'hDF;

	// Snapshot locations in Multiface RAM
	localparam logic [12:0] SNAP_PEN_IDX   = 13'h1FCF;
	localparam logic [12:0] SNAP_BORDER    = 13'h1FDF;
	localparam logic [12:0] SNAP_PEN_BASE  = 13'h1F90;
	localparam logic [12:0] SNAP_MODE      = 13'h1FEF;
	localparam logic [12:0] SNAP_BANK      = 13'h1FFF;
	localparam logic [12:0] SNAP_CRTC_SEL  = 13'h1CFF;
	localparam logic [12:0] SNAP_CRTC_BASE = 13'h1DB0;
	localparam logic [12:0] SNAP_PPI       = 13'h17FF;
	localparam logic [12:0] SNAP_ROM_SEL   = 13'h1AAC;

endpackage

//--- src/rom_loader.sv
`timescale 1ns/1ps

module rom_loader #(
	parameter int REF_DIV = 16
) (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  logic                           download,
	input  logic                           dl_wr,
	input  logic [24:0]                    dl_addr,
	input  logic [7:0]                     dl_data,
	input  logic [7:0]                     dl_index,
	input  logic [15:0]                    file_ext,
	input  logic                           model,
	output logic                           dl_wait,
	output logic                           boot_we,
	output logic [cpc_pkg::MEM_ADDR_W-1:0] boot_addr,
	output logic [1:0]                     boot_bank,
	output logic [7:0]                     boot_data
);
	import cpc_pkg::*;

	localparam int DIV_W = $clog2(REF_DIV);

	logic [DIV_W-1:0] div_cnt;
	logic             ce_ref;
	logic [PAGE_W:0]  page;      // MSB selects upper memory half
	logic             combo;     // "Z0" file puts the MF2 ROM after the first chunk
	logic             download_q;
	logic [10:0]      chunk;
	logic [4:0]       ext_hi;    // Valid flag and nibble
	logic [4:0]       ext_lo;

	function automatic logic [4:0] hex_digit(input logic [7:0] c);
		if (c >= "0" && c <= "9")
			return {1'b1, c[3:0]};
		if (c >= "A" && c <= "F")
			return {1'b1, c[3:0] + 4'd9};
		return 5'b0;
	endfunction

	assign chunk  = dl_addr[24:PAGE_OFS_W];
	assign ext_hi = hex_digit(file_ext[15:8]);
	assign ext_lo = hex_digit(file_ext[7:0]);

	//////////////////////////////////////////////////
	// Memory clock reference

	always_ff @(posedge clk_sys) begin
		if (reset || div_cnt == DIV_W'(REF_DIV - 1))
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	assign ce_ref = (div_cnt == '0);

	//////////////////////////////////////////////////
	// Byte capture and paced write

	always_ff @(posedge clk_sys) begin
		download_q <= download;
		if (reset) begin
			dl_wait <= 1'b0;
			boot_we <= 1'b0;
			combo   <= 1'b0;
			page    <= 9'h1EE;
		end else begin
			if (download && dl_wr) begin
				dl_wait   <= 1'b1;
				boot_data <= dl_data;
				boot_addr[PAGE_OFS_W-1:0] <= dl_addr[PAGE_OFS_W-1:0];
				if (dl_index != 8'd0) begin  // Expansion ROM
					boot_addr[MEM_ADDR_W-1:PAGE_OFS_W] <= {page[PAGE_W],
						page[PAGE_W-1:0] + dl_addr[PAGE_OFS_W+PAGE_W-1:PAGE_OFS_W]};
					boot_bank <= {1'b0, model};
				end else begin
					boot_bank <= {1'b0, chunk[2]};
					case (chunk)
						11'd0, 11'd4: boot_addr[MEM_ADDR_W-1:PAGE_OFS_W] <= MAIN_ROM_PAGE_LO;
						11'd1, 11'd5: boot_addr[MEM_ADDR_W-1:PAGE_OFS_W] <= MAIN_ROM_PAGE_BASIC;
						11'd2, 11'd6: boot_addr[MEM_ADDR_W-1:PAGE_OFS_W] <= MAIN_ROM_PAGE_AMSDOS;
						11'd3, 11'd7: boot_addr[MEM_ADDR_W-1:PAGE_OFS_W] <= MF2_ROM_PAGE;
						default:      dl_wait <= 1'b0; // Beyond the main ROM set
					endcase
				end
			end

			if (ce_ref) begin
				boot_we <= dl_wait;
				if (boot_we && dl_wait) begin  // Write held for one full period
					boot_we <= 1'b0;
					dl_wait <= 1'b0;
					if (combo && &boot_addr[PAGE_OFS_W-1:0]) begin
						combo <= 1'b0;
						page  <= MF2_ROM_PAGE;
					end
				end
			end

			// Page from the file extension
			if (download && !download_q && dl_index != 8'd0) begin
				combo <= 1'b0;
				if (ext_hi[4] && ext_lo[4]) begin
					page <= {1'b1, ext_hi[3:0], ext_lo[3:0]};
				end else if (file_ext == "ZZ") begin
					page <= '0;
				end else if (file_ext == "Z0") begin
					page  <= '0;
					combo <= 1'b1;
				end else begin
					page <= 9'h1EE; // Unused page
				end
			end
		end
	end

	a_wr_while_busy: assert property (@(posedge clk_sys) disable iff (reset)
		download && dl_wr |-> !dl_wait)
		else $error("byte offered while a boot write is pending");

endmodule

//--- src/rom_presence_map.sv
`timescale 1ns/1ps

module rom_presence_map (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  logic                           model_sel,
	input  logic                           boot_we,
	input  logic [cpc_pkg::MEM_ADDR_W-1:0] boot_addr,
	input  logic [cpc_pkg::MEM_ADDR_W-1:0] cpu_mem_addr,
	output logic                           model,
	output logic [7:0]                     rom_mask
);
	import cpc_pkg::*;

	logic [2**PAGE_W-1:0] rom_map = DEFAULT_ROM_PAGES;
	logic                 model_q = 1'b0;
	logic                 boot_we_q;
	logic [PAGE_W-1:0]    boot_page;
	logic [PAGE_W-1:0]    cpu_page;

	assign boot_page = boot_addr[PAGE_OFS_W +: PAGE_W];
	assign cpu_page  = cpu_mem_addr[PAGE_OFS_W +: PAGE_W];

	always_ff @(posedge clk_sys) begin
		boot_we_q <= boot_we;
		if (boot_we_q && !boot_we && boot_addr[MEM_ADDR_W-1])
			rom_map[boot_page] <= 1'b1;  // Write finished in the upper half
		if (reset) begin
			model_q <= model_sel;
			if (model_sel != model_q)
				rom_map <= DEFAULT_ROM_PAGES;
		end
	end

	assign model = model_q;

	// Empty expansion pages float high
	assign rom_mask = (cpu_mem_addr[MEM_ADDR_W-1] && !rom_map[cpu_page]) ? 8'hFF : 8'h00;

endmodule

//--- src/cpc_mem_mux.sv
`timescale 1ns/1ps

module cpc_mem_mux (
	input  logic                           clk_sys,
	input  logic                           sys_reset,
	input  logic                           boot_we,
	input  logic [cpc_pkg::MEM_ADDR_W-1:0] boot_addr,
	input  logic [1:0]                     boot_bank,
	input  logic [7:0]                     boot_data,
	input  logic                           model,
	input  logic [cpc_pkg::CPU_ADDR_W-1:0] cpu_addr,
	input  logic                           cpu_mem_rd,
	input  logic                           cpu_mem_wr,
	input  logic [cpc_pkg::MEM_ADDR_W-1:0] cpu_mem_addr,
	input  logic [7:0]                     cpu_wdata,
	input  logic                           mf2_rom_en,
	input  logic                           mf2_ram_en,
	input  logic [7:0]                     mem_rdata,
	input  logic [7:0]                     mf2_rdata,
	input  logic [7:0]                     rom_mask,
	output logic                           mem_we,
	output logic                           mem_oe,
	output logic [cpc_pkg::MEM_ADDR_W-1:0] mem_addr,
	output logic [1:0]                     mem_bank,
	output logic [7:0]                     mem_wdata,
	output logic [7:0]                     cpu_rdata
);
	import cpc_pkg::*;

	logic ram_sel_q;  // Follows the Multiface RAM read latency

	// Boot source owns memory during reset
	assign mem_we    = sys_reset ? boot_we : cpu_mem_wr && !mf2_ram_en && !mf2_rom_en;
	assign mem_oe    = !sys_reset && cpu_mem_rd && !mf2_ram_en;
	assign mem_bank  = sys_reset ? boot_bank : {1'b0, model};
	assign mem_wdata = sys_reset ? boot_data : cpu_wdata;

	always_comb begin
		if (sys_reset)
			mem_addr = boot_addr;
		else if (mf2_rom_en)
			mem_addr = {MF2_ROM_PAGE, cpu_addr[PAGE_OFS_W-1:0]};
		else
			mem_addr = cpu_mem_addr;
	end

	always_ff @(posedge clk_sys) begin
		if (sys_reset)
			ram_sel_q <= 1'b0;
		else
			ram_sel_q <= mf2_ram_en;
	end

	assign cpu_rdata = (ram_sel_q ? mf2_rdata : mem_rdata) | rom_mask;

endmodule

//--- src/mf2_control.sv
`timescale 1ns/1ps

module mf2_control (
	input  logic                           clk_sys,
	input  logic                           sys_reset,
	input  logic [1:0]                     mf2_mode,   // 0 on, 1 hidden, 2 off
	input  logic                           key_nmi,
	input  logic                           m1,
	input  logic [cpc_pkg::CPU_ADDR_W-1:0] cpu_addr,
	input  logic                           io_wr,
	output logic                           nmi,
	output logic                           mf2_active,
	output logic                           mf2_rom_en,
	output logic                           mf2_ram_en
);
	import cpc_pkg::*;

	logic hidden;
	logic key_nmi_q;
	logic m1_q;
	logic io_wr_q;
	logic m1_rise;
	logic port_hit;

	assign m1_rise  = m1 && !m1_q;
	assign port_hit = io_wr && !io_wr_q && cpu_addr[15:2] == MF2_PORT_BASE[15:2];

	always_ff @(posedge clk_sys) begin
		key_nmi_q <= key_nmi;
		m1_q      <= m1;
		io_wr_q   <= io_wr;
		if (sys_reset) begin
			nmi        <= 1'b0;
			mf2_active <= 1'b0;
			hidden     <= |mf2_mode;
		end else begin
			if (key_nmi && !key_nmi_q && !mf2_active && !mf2_mode[1])
				nmi <= 1'b1;
			if (nmi && m1_rise && cpu_addr == MF2_NMI_ENTRY) begin  // NMI taken
				nmi        <= 1'b0;
				mf2_active <= 1'b1;
				hidden     <= 1'b0;
			end
			if (mf2_active && m1_rise && cpu_addr == MF2_HIDE_ADDR)
				hidden <= 1'b1;
			if (port_hit) begin
				if (!cpu_addr[1] && !hidden) begin
					mf2_active <= 1'b1;
					nmi        <= 1'b0;  // Enable cancels a pending NMI
				end else begin
					mf2_active <= 1'b0;
				end
			end
		end
	end

	// ROM at 0000-1FFF, RAM at 2000-3FFF
	assign mf2_rom_en = mf2_active && cpu_addr[CPU_ADDR_W-1:MF2_ADDR_W] == 3'b000;
	assign mf2_ram_en = mf2_active && cpu_addr[CPU_ADDR_W-1:MF2_ADDR_W] == 3'b001;

	a_nmi_excl: assert property (@(posedge clk_sys) disable iff (sys_reset)
		!(nmi && mf2_active))
		else $error("NMI pending while Multiface active");

endmodule

//--- src/mf2_shadow.sv
`timescale 1ns/1ps

module mf2_shadow (
	input  logic                           clk_sys,
	input  logic [cpc_pkg::CPU_ADDR_W-1:0] cpu_addr,
	input  logic                           io_wr,
	input  logic [7:0]                     io_data,
	input  logic                           cpu_mem_wr,
	input  logic [cpc_pkg::MEM_ADDR_W-1:0] cpu_mem_addr,
	input  logic [7:0]                     cpu_wdata,
	input  logic                           mf2_ram_en,
	output logic [7:0]                     mf2_rdata
);
	import cpc_pkg::*;

	logic [7:0]            ram [2**MF2_ADDR_W];
	logic                  io_wr_q;
	logic                  io_wr_rise;
	logic [4:0]            pen_idx;   // Last gate array pen select
	logic [3:0]            crtc_reg;  // Last CRTC register select
	logic [MF2_ADDR_W-1:0] snap_addr;
	logic [MF2_ADDR_W-1:0] snap_addr_q;
	logic [7:0]            snap_data;
	logic                  snap_we;
	logic                  ram_we;
	logic [MF2_ADDR_W-1:0] ram_addr;
	logic [7:0]            ram_wdata;

	assign io_wr_rise = io_wr && !io_wr_q;

	//////////////////////////////////////////////////
	// Hardware register snapshot

	always_comb begin
		case (cpu_addr[15:8])
			PORT_GA: begin
				case (io_data[7:6])
					2'b00:   snap_addr = SNAP_PEN_IDX;
					2'b01:   snap_addr = pen_idx[4] ? SNAP_BORDER :
						{SNAP_PEN_BASE[MF2_ADDR_W-1:4], pen_idx[3:0]};
					2'b10:   snap_addr = SNAP_MODE;
					default: snap_addr = SNAP_BANK;
				endcase
			end
			PORT_CRTC_SEL: snap_addr = SNAP_CRTC_SEL;
			PORT_CRTC_VAL: snap_addr = {SNAP_CRTC_BASE[MF2_ADDR_W-1:4], crtc_reg};
			PORT_PPI_CTRL: snap_addr = SNAP_PPI;
			PORT_ROM_SEL:  snap_addr = SNAP_ROM_SEL;
			default:       snap_addr = '0;  // Not tracked
		endcase
	end

	always_ff @(posedge clk_sys) begin
		io_wr_q     <= io_wr;
		snap_we     <= io_wr_rise && snap_addr != '0;
		snap_addr_q <= snap_addr;
		snap_data   <= io_data;
		if (io_wr_rise && cpu_addr[15:8] == PORT_GA && io_data[7:6] == 2'b00)
			pen_idx <= io_data[4:0];
		if (io_wr_rise && cpu_addr[15:8] == PORT_CRTC_SEL)
			crtc_reg <= io_data[3:0];
	end

	//////////////////////////////////////////////////
	// RAM port, snapshot first

	assign ram_we    = snap_we || (cpu_mem_wr && mf2_ram_en);
	assign ram_addr  = snap_we ? snap_addr_q : cpu_mem_addr[MF2_ADDR_W-1:0];
	assign ram_wdata = snap_we ? snap_data : cpu_wdata;

	always_ff @(posedge clk_sys) begin
		if (ram_we)
			ram[ram_addr] <= ram_wdata;
		mf2_rdata <= ram[ram_addr];
	end

endmodule

//--- src/fdc_io_port.sv
`timescale 1ns/1ps

module fdc_io_port (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  logic [cpc_pkg::CPU_ADDR_W-1:0] cpu_addr,
	input  logic                           io_wr,
	input  logic                           io_rd,
	input  logic [7:0]                     io_data,
	input  logic [1:0]                     img_mounted,
	input  logic [7:0]                     fdc_status_a,
	input  logic [7:0]                     fdc_status_b,
	input  logic [7:0]                     fdc_data_a,
	input  logic [7:0]                     fdc_data_b,
	output logic                           motor,
	output logic [7:0]                     fdc_rdata
);
	logic [3:0] fdc_sel;
	logic       io_wr_q;

	assign fdc_sel = {cpu_addr[10], cpu_addr[8], cpu_addr[7], cpu_addr[0]};

	always_ff @(posedge clk_sys) begin
		io_wr_q <= io_wr;
		if (reset)
			motor <= 1'b0;
		else if (|img_mounted)
			motor <= 1'b0;  // New disk stops the drive
		else if (io_wr && !io_wr_q && fdc_sel[3:1] == 3'b000)
			motor <= io_data[0];
	end

	always_comb begin
		fdc_rdata = 8'hFF;
		if (io_rd) begin
			casez (fdc_sel)
				4'b000?: fdc_rdata = {7'd0, motor};
				4'b0100: fdc_rdata = {fdc_status_a[7] & fdc_status_b[7],
					fdc_status_a[6:0] | fdc_status_b[6:0]};  // Main status
				4'b0101: fdc_rdata = fdc_data_a | fdc_data_b;
				default: fdc_rdata = 8'hFF;
			endcase
		end
	end

endmodule

//--- src/cpc_expansion_top.sv
`timescale 1ns/1ps

module cpc_expansion_top #(
	parameter int REF_DIV = 16
) (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  logic                           model_sel,
	input  logic [1:0]                     mf2_mode,
	// Download stream
	input  logic                           download,
	input  logic [7:0]                     dl_index,
	input  logic [15:0]                    file_ext,
	input  logic                           dl_wr,
	input  logic [24:0]                    dl_addr,
	input  logic [7:0]                     dl_data,
	output logic                           dl_wait,
	// Memory
	output logic                           mem_we,
	output logic                           mem_oe,
	output logic [cpc_pkg::MEM_ADDR_W-1:0] mem_addr,
	output logic [1:0]                     mem_bank,
	output logic [7:0]                     mem_wdata,
	input  logic [7:0]                     mem_rdata,
	// CPU bus
	input  logic [cpc_pkg::CPU_ADDR_W-1:0] cpu_addr,
	input  logic                           cpu_mem_rd,
	input  logic                           cpu_mem_wr,
	input  logic [cpc_pkg::MEM_ADDR_W-1:0] cpu_mem_addr,
	input  logic [7:0]                     cpu_wdata,
	output logic [7:0]                     cpu_rdata,
	input  logic                           io_wr,
	input  logic                           io_rd,
	input  logic [7:0]                     io_data,
	input  logic                           m1,
	// Multiface
	input  logic                           key_nmi,
	output logic                           nmi,
	output logic                           mf2_active,
	// Floppy controllers
	input  logic [1:0]                     img_mounted,
	input  logic [7:0]                     fdc_status_a,
	input  logic [7:0]                     fdc_status_b,
	input  logic [7:0]                     fdc_data_a,
	input  logic [7:0]                     fdc_data_b,
	output logic                           motor,
	output logic [7:0]                     fdc_rdata
);
	import cpc_pkg::*;

	logic                  sys_reset;
	logic                  model;
	logic                  boot_we;
	logic [MEM_ADDR_W-1:0] boot_addr;
	logic [1:0]            boot_bank;
	logic [7:0]            boot_data;
	logic [7:0]            rom_mask;
	logic                  mf2_rom_en;
	logic                  mf2_ram_en;
	logic [7:0]            mf2_rdata;

	assign sys_reset = reset | download;  // CPU held off during a download

	//////////////////////////////////////////////////
	// ROM loading and memory

	rom_loader #(.REF_DIV(REF_DIV)) u_loader (
		.clk_sys, .reset, .download, .dl_wr, .dl_addr, .dl_data, .dl_index, .file_ext,
		.model, .dl_wait, .boot_we, .boot_addr, .boot_bank, .boot_data
	);

	rom_presence_map u_rom_map (
		.clk_sys, .reset(sys_reset), .model_sel, .boot_we, .boot_addr, .cpu_mem_addr,
		.model, .rom_mask
	);

	cpc_mem_mux u_mem_mux (
		.clk_sys, .sys_reset, .boot_we, .boot_addr, .boot_bank, .boot_data, .model,
		.cpu_addr, .cpu_mem_rd, .cpu_mem_wr, .cpu_mem_addr, .cpu_wdata,
		.mf2_rom_en, .mf2_ram_en, .mem_rdata, .mf2_rdata, .rom_mask,
		.mem_we, .mem_oe, .mem_addr, .mem_bank, .mem_wdata, .cpu_rdata
	);

	//////////////////////////////////////////////////
	// Multiface Two and floppy port

	mf2_control u_mf2_ctrl (
		.clk_sys, .sys_reset, .mf2_mode, .key_nmi, .m1, .cpu_addr, .io_wr,
		.nmi, .mf2_active, .mf2_rom_en, .mf2_ram_en
	);

	mf2_shadow u_mf2_shadow (
		.clk_sys, .cpu_addr, .io_wr, .io_data, .cpu_mem_wr, .cpu_mem_addr, .cpu_wdata,
		.mf2_ram_en, .mf2_rdata
	);

	fdc_io_port u_fdc_port (
		.clk_sys, .reset, .cpu_addr, .io_wr, .io_rd, .io_data, .img_mounted,
		.fdc_status_a, .fdc_status_b, .fdc_data_a, .fdc_data_b, .motor, .fdc_rdata
	);

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter real PERIOD       = 4.0,
	parameter int  RESET_CYCLES = 4
) (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD / 2.0) clk_sys = ~clk_sys;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		reset <= 1'b0;  // Released on a rising edge
	end

endmodule

//--- verification/tb_cases.svh
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

typedef enum int {
	OP_DL_START, OP_DL_BYTE, OP_DL_SKIP, OP_DL_END,
	OP_MEM_RD, OP_ROM_RD, OP_MODEL,
	OP_KEY_NMI, OP_M1, OP_IO_WR, OP_FLAGS,
	OP_FDC_RD, OP_MOUNT
} tb_op_t;

typedef struct {
	string       name;
	tb_op_t      op;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] expected;
} tb_case_t;

localparam logic [31:0] EXP_MEM   = 32'h100;  // Read returns the random memory byte
localparam int          NUM_CASES = 47;

// Columns: name, operation, address or index, data or extension, expected value
// Download rows expect {bank, page}, flag rows expect {nmi, mf2_active}
tb_case_t cases [NUM_CASES] = '{
	'{"main_start",      OP_DL_START, 32'h0,       32'h0,         32'h0},
	'{"main_c0",         OP_DL_BYTE,  32'h0000000, 32'h0,         32'h000},
	'{"main_c1",         OP_DL_BYTE,  32'h0004123, 32'h0,         32'h100},
	'{"main_c2",         OP_DL_BYTE,  32'h000BFFF, 32'h0,         32'h107},
	'{"main_c3",         OP_DL_BYTE,  32'h000C042, 32'h0,         32'h1FF},
	'{"main_c4",         OP_DL_BYTE,  32'h0011000, 32'h0,         32'h200},
	'{"main_c5",         OP_DL_BYTE,  32'h0014001, 32'h0,         32'h300},
	'{"main_c6",         OP_DL_BYTE,  32'h001AAAA, 32'h0,         32'h307},
	'{"main_c7",         OP_DL_BYTE,  32'h001FFFE, 32'h0,         32'h3FF},
	'{"main_c8_skip",    OP_DL_SKIP,  32'h0020000, 32'h0,         32'h0},
	'{"main_end",        OP_DL_END,   32'h0,       32'h0,         32'h0},
	'{"exp_start",       OP_DL_START, 32'h1,       32'h3043,      32'h0},  // "0C"
	'{"exp_c0",          OP_DL_BYTE,  32'h0000123, 32'h0,         32'h10C},
	'{"exp_c1",          OP_DL_BYTE,  32'h0006000, 32'h0,         32'h10D},
	'{"exp_end",         OP_DL_END,   32'h0,       32'h0,         32'h0},
	'{"rd_page_0c",      OP_MEM_RD,   32'h430123,  32'h0,         EXP_MEM},
	'{"rd_page_0d",      OP_MEM_RD,   32'h436000,  32'h0,         EXP_MEM},
	'{"rd_page_20",      OP_MEM_RD,   32'h480000,  32'h0,         32'hFF},
	'{"rd_page_00",      OP_MEM_RD,   32'h400000,  32'h0,         EXP_MEM},
	'{"model_toggle",    OP_MODEL,    32'h1,       32'h0,         32'h0},
	'{"model_page_00",   OP_MEM_RD,   32'h400010,  32'h0,         EXP_MEM},
	'{"model_page_07",   OP_MEM_RD,   32'h41C000,  32'h0,         EXP_MEM},
	'{"model_page_ff",   OP_MEM_RD,   32'h7FC000,  32'h0,         EXP_MEM},
	'{"model_page_0c",   OP_MEM_RD,   32'h430123,  32'h0,         32'hFF},
	'{"nmi_key",         OP_KEY_NMI,  32'h0,       32'h0,         32'h0},
	'{"nmi_pending",     OP_FLAGS,    32'h0,       32'h0,         32'h2},
	'{"nmi_entry",       OP_M1,       32'h0066,    32'h0,         32'h0},
	'{"mf2_on",          OP_FLAGS,    32'h0,       32'h0,         32'h1},
	'{"mf2_rom_rd",      OP_ROM_RD,   32'h0100,    32'h0,         32'h7FC100},
	'{"mf2_off_wr",      OP_IO_WR,    32'hFEEA,    32'h00,        32'h0},
	'{"mf2_off",         OP_FLAGS,    32'h0,       32'h0,         32'h0},
	'{"mf2_en_wr",       OP_IO_WR,    32'hFEE8,    32'h00,        32'h0},
	'{"mf2_en",          OP_FLAGS,    32'h0,       32'h0,         32'h1},
	'{"ga_pen_sel",      OP_IO_WR,    32'h7F00,    32'h03,        32'h0},
	'{"ga_colour",       OP_IO_WR,    32'h7F00,    32'h55,        32'h0},
	'{"snap_colour",     OP_MEM_RD,   32'h3F93,    32'h0,         32'h55},
	'{"crtc_sel",        OP_IO_WR,    32'hBC00,    32'h05,        32'h0},
	'{"crtc_val",        OP_IO_WR,    32'hBD00,    32'h3A,        32'h0},
	'{"snap_crtc",       OP_MEM_RD,   32'h3DB5,    32'h0,         32'h3A},
	'{"motor_on_wr",     OP_IO_WR,    32'hFA7E,    32'h01,        32'h0},
	'{"motor_on",        OP_FDC_RD,   32'hFA7E,    32'h0,         32'h01},
	'{"disk_mount",      OP_MOUNT,    32'h1,       32'h0,         32'h0},
	'{"motor_off",       OP_FDC_RD,   32'hFA7E,    32'h0,         32'h00},
	'{"fdc_status_rdy",  OP_FDC_RD,   32'hFB7E,    32'hD085_0000, 32'hD5},
	'{"fdc_status_busy", OP_FDC_RD,   32'hFB7E,    32'h9010_0000, 32'h10},
	'{"fdc_data",        OP_FDC_RD,   32'hFB7F,    32'h0000_1240, 32'h52},
	'{"fdc_no_port",     OP_FDC_RD,   32'h7F00,    32'h0,         32'hFF}
};

`endif

//--- verification/tb_cpc_expansion.sv
`timescale 1ns/1ps

module tb_cpc_expansion;
	import cpc_pkg::*;

	localparam int REF_DIV = 8;
	localparam int TIMEOUT = 4 * REF_DIV;  // Cycles allowed for any single wait
	localparam logic [15:0] MOTOR_PORT = 16'hFA7E;  // Floppy motor latch

	logic                  clk_sys;
	logic                  por;
	logic                  reset_pulse;
	logic                  reset;
	logic                  model_sel;
	logic [1:0]            mf2_mode;
	logic                  download;
	logic [7:0]            dl_index;
	logic [15:0]           file_ext;
	logic                  dl_wr;
	logic [24:0]           dl_addr;
	logic [7:0]            dl_data;
	logic                  dl_wait;
	logic                  mem_we;
	logic                  mem_oe;
	logic [MEM_ADDR_W-1:0] mem_addr;
	logic [1:0]            mem_bank;
	logic [7:0]            mem_wdata;
	logic [7:0]            mem_rdata;
	logic [CPU_ADDR_W-1:0] cpu_addr;
	logic                  cpu_mem_rd;
	logic                  cpu_mem_wr;
	logic [MEM_ADDR_W-1:0] cpu_mem_addr;
	logic [7:0]            cpu_wdata;
	logic [7:0]            cpu_rdata;
	logic                  io_wr;
	logic                  io_rd;
	logic [7:0]            io_data;
	logic                  m1;
	logic                  key_nmi;
	logic                  nmi;
	logic                  mf2_active;
	logic [1:0]            img_mounted;
	logic [7:0]            fdc_status_a;
	logic [7:0]            fdc_status_b;
	logic [7:0]            fdc_data_a;
	logic [7:0]            fdc_data_b;
	logic                  motor;
	logic [7:0]            fdc_rdata;

	logic [31:0] lfsr;
	int          mismatches = 0;
	int          timeouts = 0;

	`include "tb_cases.svh"

	assign reset = por | reset_pulse;  // Power-on reset or a model change pulse

	tb_clock_gen #(.PERIOD(4.0), .RESET_CYCLES(4)) u_clock (.clk_sys, .reset(por));

	cpc_expansion_top #(.REF_DIV(REF_DIV)) UUT (.*);

	//////////////////////////////////////////////////
	// Helpers

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
	endfunction

	task automatic random_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_step(lfsr);
			b = {b[6:0], lfsr[0]};
		end
	endtask

	task automatic check_value(input string name, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		assert (actual === expected)
		else begin
			mismatches++;
			$display("mismatch %s %s: expected %0h, actual %0h", name, what, expected, actual);
		end
	endtask

	task automatic init_inputs();
		reset_pulse = 1'b0;
		model_sel = 1'b0;
		mf2_mode = 2'd0;
		download = 1'b0;
		dl_index = 8'd0;
		file_ext = 16'd0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = 8'd0;
		mem_rdata = 8'd0;
		cpu_addr = '0;
		cpu_mem_rd = 1'b0;
		cpu_mem_wr = 1'b0;
		cpu_mem_addr = '0;
		cpu_wdata = 8'd0;
		io_wr = 1'b0;
		io_rd = 1'b0;
		io_data = 8'd0;
		m1 = 1'b0;
		key_nmi = 1'b0;
		img_mounted = 2'd0;
		{fdc_status_a, fdc_status_b, fdc_data_a, fdc_data_b} = '0;
	endtask

	//////////////////////////////////////////////////
	// One table row

	task automatic run_case(input tb_case_t c);
		int          cnt;
		logic [7:0]  data;
		logic [31:0] exp_val;
		case (c.op)
			OP_DL_START, OP_DL_END: begin
				@(posedge clk_sys);
				download <= (c.op == OP_DL_START);
				dl_index <= c.a[7:0];
				file_ext <= c.b[15:0];
				repeat (2) @(posedge clk_sys);  // Page decodes on the download edge
			end
			OP_DL_BYTE: begin
				random_byte(data);
				@(posedge clk_sys);
				dl_addr <= c.a[24:0];
				dl_data <= data;
				dl_wr   <= 1'b1;
				@(posedge clk_sys);
				dl_wr <= 1'b0;
				@(negedge clk_sys);
				check_value(c.name, "dl_wait", 1, dl_wait);
				cnt = 0;
				while (!mem_we && cnt < TIMEOUT) begin
					@(negedge clk_sys);
					cnt++;
				end
				assert (mem_we)
				else begin
					timeouts++;
					$display("timeout in %s: memory write never started", c.name);
				end
				check_value(c.name, "mem_addr", {c.expected[8:0], c.a[13:0]}, mem_addr);
				check_value(c.name, "mem_bank", c.expected[10:9], mem_bank);
				check_value(c.name, "mem_wdata", data, mem_wdata);
				cnt = 0;
				while (dl_wait && cnt < TIMEOUT) begin
					@(negedge clk_sys);
					cnt++;
				end
				assert (!dl_wait)
				else begin
					timeouts++;
					$display("timeout in %s: write never completed", c.name);
				end
				check_value(c.name, "mem_we at end", 0, mem_we);
			end
			OP_DL_SKIP: begin
				@(posedge clk_sys);
				dl_addr <= c.a[24:0];
				dl_wr   <= 1'b1;
				@(posedge clk_sys);
				dl_wr <= 1'b0;
				cnt = 0;
				repeat (2 * REF_DIV) begin
					@(negedge clk_sys);
					cnt += dl_wait | mem_we;
				end
				assert (cnt == 0)
				else begin
					mismatches++;
					$display("%s: ignored chunk raised dl_wait or a memory write", c.name);
				end
			end
			OP_MEM_RD, OP_ROM_RD: begin
				random_byte(data);
				@(posedge clk_sys);
				cpu_addr     <= c.a[15:0];
				cpu_mem_addr <= c.a[MEM_ADDR_W-1:0];
				cpu_mem_rd   <= 1'b1;
				mem_rdata    <= data;
				@(posedge clk_sys);  // Multiface RAM answers one cycle later
				@(negedge clk_sys);
				if (c.op == OP_ROM_RD) begin
					check_value(c.name, "mem_addr", c.expected, mem_addr);
					check_value(c.name, "mem_oe", 1, mem_oe);
				end else begin
					exp_val = (c.expected == EXP_MEM) ? {24'd0, data} : c.expected;
					check_value(c.name, "cpu_rdata", exp_val, cpu_rdata);
				end
				@(posedge clk_sys);
				cpu_mem_rd <= 1'b0;
			end
			OP_MODEL: begin
				@(posedge clk_sys);
				model_sel <= c.a[0];
				@(posedge clk_sys);
				reset_pulse <= 1'b1;
				repeat (2) @(posedge clk_sys);
				reset_pulse <= 1'b0;
				@(posedge clk_sys);
			end
			OP_KEY_NMI, OP_M1, OP_MOUNT: begin
				@(posedge clk_sys);
				if (c.op == OP_KEY_NMI)
					key_nmi <= 1'b1;
				else if (c.op == OP_M1) begin
					cpu_addr <= c.a[15:0];
					m1       <= 1'b1;
				end else
					img_mounted <= c.a[1:0];
				@(posedge clk_sys);
				key_nmi     <= 1'b0;
				m1          <= 1'b0;
				img_mounted <= 2'd0;
			end
			OP_IO_WR: begin
				@(posedge clk_sys);
				cpu_addr <= c.a[15:0];
				io_data  <= c.b[7:0];
				io_wr    <= 1'b1;
				@(posedge clk_sys);
				io_wr <= 1'b0;
				repeat (2) @(posedge clk_sys);  // Snapshot reaches RAM two cycles after the edge
			end
			OP_FLAGS: begin
				@(negedge clk_sys);
				cnt = 0;
				while ({nmi, mf2_active} !== c.expected[1:0] && cnt < TIMEOUT) begin
					@(negedge clk_sys);
					cnt++;
				end
				check_value(c.name, "nmi,mf2_active", c.expected[1:0], {nmi, mf2_active});
			end
			OP_FDC_RD: begin
				@(posedge clk_sys);
				cpu_addr <= c.a[15:0];
				io_rd    <= 1'b1;
				{fdc_status_a, fdc_status_b, fdc_data_a, fdc_data_b} <= c.b;
				@(negedge clk_sys);
				check_value(c.name, "fdc_rdata", c.expected, fdc_rdata);
				if (c.a[15:0] == MOTOR_PORT)
					check_value(c.name, "motor", c.expected[0], motor);
				@(posedge clk_sys);
				io_rd <= 1'b0;
			end
		endcase
	endtask

	//////////////////////////////////////////////////
	// Main sequence

	initial begin
		int cnt;
		init_inputs();
		lfsr = 32'h7525_9c4b;
		cnt = 0;
		while (por !== 1'b0 && cnt < TIMEOUT) begin
			@(negedge clk_sys);
			cnt++;
		end
		assert (por === 1'b0)
		else begin
			timeouts++;
			$display("timeout: reset was never released");
		end
		foreach (cases[i])
			run_case(cases[i]);
		repeat (2) @(posedge clk_sys);
		$display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- tb.f
+incdir+verification
src/cpc_pkg.sv
src/rom_loader.sv
src/rom_presence_map.sv
src/cpc_mem_mux.sv
src/mf2_control.sv
src/mf2_shadow.sv
src/fdc_io_port.sv
src/cpc_expansion_top.sv
verification/tb_clock_gen.sv
verification/tb_cpc_expansion.sv

//--- Bender.yml
package:
  name: cpc_expansion

sources:
  - files:
      - src/cpc_pkg.sv
      - src/rom_loader.sv
      - src/rom_presence_map.sv
      - src/cpc_mem_mux.sv
      - src/mf2_control.sv
      - src/mf2_shadow.sv
      - src/fdc_io_port.sv
      - src/cpc_expansion_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_cpc_expansion.sv
